// File: compile.f
hw/axi_pkg.sv
hw/sram_pkg.sv
hw/sram_port_arb.sv
hw/sram_byte_lane.sv
hw/axi_write_ctrl.sv
hw/axi_read_ctrl.sv
hw/sram_axi_slave.sv
dv/sram_axi_slave_properties.sv
dv/sram_axi_slave_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= sram_axi_slave_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "sim: failure reported in $(LOG)"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || { echo "sim: run ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/sram_axi_slave_tb.sv
`timescale 1ns/1ps

module sram_axi_slave_tb;
    import axi_pkg::*;
    import sram_pkg::*;

    localparam int TIMEOUT = 1000;  // cycles per wait
    localparam logic [1:0] OP_WR   = 2'd0;
    localparam logic [1:0] OP_RD   = 2'd1;
    localparam logic [1:0] OP_BOTH = 2'd2;  // write at addr and read at addr2 together
    localparam axi_burst_t BURST_WRAP = 2'b10;

    typedef struct packed {
        logic [1:0] op;
        axi_id_t    id;
        axi_addr_t  addr;
        axi_addr_t  addr2;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
        axi_strb_t  strb;
        axi_resp_t  resp;   // expected response
        logic       stall;  // random r_ready gaps
    } entry_t;

    localparam int NUM = 21;
    localparam entry_t STIM [NUM] = '{
        '{OP_WR, 4'h1, 32'h0000, 32'h0, 8'd7, 3'd2, BURST_INCR, 4'hf, RESP_OKAY, 1'b0},
        '{OP_RD, 4'h2, 32'h0000, 32'h0, 8'd7, 3'd2, BURST_INCR, 4'h0, RESP_OKAY, 1'b0},
        '{OP_WR, 4'h3, 32'h0100, 32'h0, 8'd15, 3'd2, BURST_INCR, 4'hf, RESP_OKAY, 1'b0},
        '{OP_WR, 4'h4, 32'h0104, 32'h0, 8'd3, 3'd2, BURST_INCR, 4'h5, RESP_OKAY, 1'b0},
        '{OP_WR, 4'h5, 32'h0111, 32'h0, 8'd5, 3'd0, BURST_INCR, 4'hf, RESP_OKAY, 1'b0},
        '{OP_WR, 4'h6, 32'h0122, 32'h0, 8'd3, 3'd1, BURST_INCR, 4'hf, RESP_OKAY, 1'b0},
        '{OP_WR, 4'h7, 32'h0130, 32'h0, 8'd3, 3'd2, BURST_FIXED, 4'h6, RESP_OKAY, 1'b0},
        '{OP_RD, 4'h8, 32'h0100, 32'h0, 8'd15, 3'd2, BURST_INCR, 4'h0, RESP_OKAY, 1'b0},
        '{OP_WR, 4'h9, 32'h10000, 32'h0, 8'd3, 3'd2, BURST_INCR, 4'hf, RESP_DECERR, 1'b0},
        '{OP_RD, 4'ha, 32'h10000, 32'h0, 8'd3, 3'd2, BURST_INCR, 4'h0, RESP_DECERR, 1'b0},
        '{OP_WR, 4'hb, 32'h0100, 32'h0, 8'd1, 3'd3, BURST_INCR, 4'hf, RESP_SLVERR, 1'b0},
        '{OP_RD, 4'hc, 32'h0100, 32'h0, 8'd2, 3'd3, BURST_INCR, 4'h0, RESP_SLVERR, 1'b0},
        '{OP_WR, 4'hd, 32'h0100, 32'h0, 8'd1, 3'd2, BURST_WRAP, 4'hf, RESP_SLVERR, 1'b0},
        '{OP_RD, 4'he, 32'h0100, 32'h0, 8'd3, 3'd2, BURST_WRAP, 4'h0, RESP_SLVERR, 1'b0},
        '{OP_RD, 4'hf, 32'h0100, 32'h0, 8'd15, 3'd2, BURST_INCR, 4'h0, RESP_OKAY, 1'b1},
        '{OP_RD, 4'h1, 32'h0000, 32'h0, 8'd7, 3'd2, BURST_INCR, 4'h0, RESP_OKAY, 1'b1},
        '{OP_WR, 4'h2, 32'h0200, 32'h0, 8'd255, 3'd2, BURST_INCR, 4'hf, RESP_OKAY, 1'b0},
        '{OP_RD, 4'h3, 32'h0200, 32'h0, 8'd255, 3'd2, BURST_INCR, 4'h0, RESP_OKAY, 1'b1},
        '{OP_BOTH, 4'h4, 32'h0800, 32'h0200, 8'd15, 3'd2, BURST_INCR, 4'hf, RESP_OKAY, 1'b1},
        '{OP_RD, 4'h5, 32'h0800, 32'h0, 8'd15, 3'd2, BURST_INCR, 4'h0, RESP_OKAY, 1'b0},
        '{OP_RD, 4'h6, 32'h0130, 32'h0, 8'd2, 3'd2, BURST_FIXED, 4'h0, RESP_OKAY, 1'b1}
    };

    logic ACLK;
    logic ARESETn;
    axi_id_t    aw_id, b_id, ar_id, r_id;
    axi_addr_t  aw_addr, ar_addr;
    axi_len_t   aw_len, ar_len;
    axi_size_t  aw_size, ar_size;
    axi_burst_t aw_burst, ar_burst;
    axi_data_t  w_data, r_data;
    axi_strb_t  w_strb;
    axi_resp_t  b_resp, r_resp;
    logic aw_valid, aw_ready, w_last, w_valid, w_ready, b_valid, b_ready;
    logic ar_valid, ar_ready, r_last, r_valid, r_ready;

    logic [7:0]  shadow [SRAM_BYTES];  // byte image of what the dut should hold
    logic [31:0] data_rng;
    logic [31:0] stall_rng;
    int errors;
    int timeouts;
    entry_t e;

    sram_axi_slave #(.DEPTH_BITS(14)) sram_axi_slave_inst (.*);

    initial begin
        ACLK = 1'b0;
        forever #10 ACLK = ~ACLK;  // 20 ns period
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // lanes a narrow beat may touch
    function automatic axi_strb_t lane_mask(input axi_addr_t a, input axi_size_t s);
        case (s)
            3'd0: return axi_strb_t'(4'b0001 << a[1:0]);
            3'd1: return a[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic axi_data_t expected_word(input axi_addr_t a);
        logic [15:0] base;
        base = {a[15:2], 2'b00};
        return {shadow[base + 16'd3], shadow[base + 16'd2], shadow[base + 16'd1], shadow[base]};
    endfunction

    function automatic int assertion_failures();
        return sram_axi_slave_inst.sram_axi_slave_properties_inst.r_hold_fails
             + sram_axi_slave_inst.sram_axi_slave_properties_inst.b_hold_fails
             + sram_axi_slave_inst.sram_axi_slave_properties_inst.last_fails;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("Summary: %0d check errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, assertion_failures());
    endtask

    task automatic abort_on_timeout(input string what);
        timeouts++;
        $display("Timeout: no %s within %0d cycles, stopping the run", what, TIMEOUT);
        print_counts();
        $display("Regression failed");
        $finish;
    endtask

    task automatic write_burst(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                               input axi_size_t size, input axi_burst_t burst,
                               input axi_strb_t strb, input axi_resp_t resp);
        axi_addr_t   a;
        axi_strb_t   s;
        axi_data_t   d;
        logic [15:0] base;
        int t;
        aw_id    <= id;
        aw_addr  <= addr;
        aw_len   <= len;
        aw_size  <= size;
        aw_burst <= burst;
        aw_valid <= 1'b1;
        t = 0;
        @(posedge ACLK);
        while (!aw_ready) begin
            t++;
            if (t > TIMEOUT) abort_on_timeout("aw_ready");
            @(posedge ACLK);
        end
        aw_valid <= 1'b0;
        a = addr;
        for (int n = 0; n <= int'(len); n++) begin
            data_rng = xorshift(data_rng);
            d = data_rng;
            s = strb & lane_mask(a, size);  // only lanes of this beat
            w_data  <= d;
            w_strb  <= s;
            w_last  <= (n == int'(len));
            w_valid <= 1'b1;
            t = 0;
            @(posedge ACLK);
            while (!w_ready) begin
                t++;
                if (t > TIMEOUT) abort_on_timeout("w_ready");
                @(posedge ACLK);
            end
            if (resp == RESP_OKAY) begin
                base = {a[15:2], 2'b00};
                for (int i = 0; i < SRAM_LANES; i++) begin
                    if (s[i]) shadow[base + 16'(i)] = d[8*i +: 8];
                end
            end
            if (burst == BURST_INCR) a = a + (axi_addr_t'(1) << size);  // fixed stays
        end
        w_valid <= 1'b0;
        w_last  <= 1'b0;
        b_ready <= d[0];  // last beat's data picks b back-pressure
        @(posedge ACLK);
        check("b_valid", 32'(b_valid), 32'd1);  // one cycle after w_last
        check("b_resp", 32'(b_resp), 32'(resp));
        check("b_id", 32'(b_id), 32'(id));
        if (!b_ready) begin
            b_ready <= 1'b1;
            @(posedge ACLK);
            check("b_valid", 32'(b_valid), 32'd1);  // held over the stall
        end
    endtask

    task automatic read_burst(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                              input axi_size_t size, input axi_burst_t burst,
                              input axi_resp_t resp, input logic stall);
        axi_addr_t a;
        axi_data_t exp_data;
        int beat;
        int t;
        ar_id    <= id;
        ar_addr  <= addr;
        ar_len   <= len;
        ar_size  <= size;
        ar_burst <= burst;
        ar_valid <= 1'b1;
        t = 0;
        @(posedge ACLK);
        while (!ar_ready) begin
            t++;
            if (t > TIMEOUT) abort_on_timeout("ar_ready");
            @(posedge ACLK);
        end
        ar_valid <= 1'b0;
        a = addr;
        beat = 0;
        t = 0;
        while (beat <= int'(len)) begin
            stall_rng = xorshift(stall_rng);
            r_ready <= stall ? stall_rng[0] : 1'b1;
            @(posedge ACLK);
            if (r_valid && r_ready) begin
                exp_data = (resp == RESP_OKAY) ? expected_word(a) : '0;  // error beats are zero
                check("r_data", r_data, exp_data);
                check("r_resp", 32'(r_resp), 32'(resp));
                check("r_id", 32'(r_id), 32'(id));
                check("r_last", 32'(r_last), 32'(beat == int'(len)));
                if (burst == BURST_INCR) a = a + (axi_addr_t'(1) << size);
                beat++;
                t = 0;
            end else begin
                t++;
                if (t > TIMEOUT) abort_on_timeout("read beat");
            end
        end
        r_ready <= 1'b0;
        @(posedge ACLK);
        check("r_valid", 32'(r_valid), 32'd0);  // nothing past beat len+1
    endtask

    initial begin
        ARESETn  = 1'b0;
        aw_id    = '0;
        aw_addr  = '0;
        aw_len   = '0;
        aw_size  = '0;
        aw_burst = '0;
        aw_valid = 1'b0;
        w_data   = '0;
        w_strb   = '0;
        w_last   = 1'b0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar_id    = '0;
        ar_addr  = '0;
        ar_len   = '0;
        ar_size  = '0;
        ar_burst = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        data_rng  = 32'd63240;
        stall_rng = xorshift(32'd63240);
        errors   = 0;
        timeouts = 0;
        repeat (2) @(posedge ACLK);
        ARESETn <= 1'b1;
        b_ready <= 1'b1;
        @(posedge ACLK);
        // idle values out of reset
        check("aw_ready", 32'(aw_ready), 32'd1);
        check("ar_ready", 32'(ar_ready), 32'd1);
        check("w_ready", 32'(w_ready), 32'd0);
        check("b_valid", 32'(b_valid), 32'd0);
        check("r_valid", 32'(r_valid), 32'd0);
        for (int k = 0; k < NUM; k++) begin
            e = STIM[k];
            case (e.op)
                OP_WR: write_burst(e.id, e.addr, e.len, e.size, e.burst, e.strb, e.resp);
                OP_RD: read_burst(e.id, e.addr, e.len, e.size, e.burst, e.resp, e.stall);
                default: begin
                    fork
                        write_burst(e.id, e.addr, e.len, e.size, e.burst, e.strb, e.resp);
                        read_burst(e.id ^ 4'hf, e.addr2, e.len, 3'd2, BURST_INCR,
                                   RESP_OKAY, e.stall);
                    join
                end
            endcase
        end
        repeat (2) @(posedge ACLK);
        print_counts();
        if (errors == 0 && assertion_failures() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: dv/sram_axi_slave_properties.sv
`timescale 1ns/1ps

module sram_axi_slave_properties import axi_pkg::*; (
    input logic      ACLK,
    input logic      ARESETn,
    input axi_id_t   r_id,
    input axi_data_t r_data,
    input axi_resp_t r_resp,
    input logic      r_last,
    input logic      r_valid,
    input logic      r_ready,
    input logic      b_valid,
    input logic      b_ready
);

    int r_hold_fails = 0;  // read by the testbench at the end
    int b_hold_fails = 0;
    int last_fails   = 0;

    // stalled read beat keeps valid and payload
    r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_resp)
                                && $stable(r_last) && $stable(r_id))
        else begin
            r_hold_fails++;
            $error("r channel changed while r_ready was low");
        end

    b_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        b_valid && !b_ready |=> b_valid)
        else begin
            b_hold_fails++;
            $error("b_valid dropped before b_ready");
        end

    last_valid: assert property (@(posedge ACLK) disable iff (!ARESETn) r_last |-> r_valid)
        else begin
            last_fails++;
            $error("r_last high without r_valid");
        end

endmodule

bind sram_axi_slave sram_axi_slave_properties sram_axi_slave_properties_inst (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .r_id(r_id), .r_data(r_data), .r_resp(r_resp), .r_last(r_last),
    .r_valid(r_valid), .r_ready(r_ready),
    .b_valid(b_valid), .b_ready(b_ready)
);

// File: hw/sram_axi_slave.sv
`timescale 1ns/1ps

module sram_axi_slave import axi_pkg::*, sram_pkg::*; #(
    parameter int DEPTH_BITS = 14  // 16K words of 4 bytes
) (
    input  logic       ACLK,
    input  logic       ARESETn,
    input  axi_id_t    aw_id,
    input  axi_addr_t  aw_addr,
    input  axi_len_t   aw_len,
    input  axi_size_t  aw_size,
    input  axi_burst_t aw_burst,
    input  logic       aw_valid,
    output logic       aw_ready,
    input  axi_data_t  w_data,
    input  axi_strb_t  w_strb,
    input  logic       w_last,
    input  logic       w_valid,
    output logic       w_ready,
    output axi_id_t    b_id,
    output axi_resp_t  b_resp,
    output logic       b_valid,
    input  logic       b_ready,
    input  axi_id_t    ar_id,
    input  axi_addr_t  ar_addr,
    input  axi_len_t   ar_len,
    input  axi_size_t  ar_size,
    input  axi_burst_t ar_burst,
    input  logic       ar_valid,
    output logic       ar_ready,
    output axi_id_t    r_id,
    output axi_data_t  r_data,
    output axi_resp_t  r_resp,
    output logic       r_last,
    output logic       r_valid,
    input  logic       r_ready
);

    logic                   wr_req, wr_gnt, rd_req, rd_gnt;
    logic [DEPTH_BITS-1:0]  wr_word_addr, rd_word_addr, lane_addr;
    axi_data_t              wr_data;
    axi_strb_t              wr_strb;
    logic                   lane_en;
    logic [SRAM_LANES-1:0]  lane_we;
    byte_t [SRAM_LANES-1:0] lane_wdata, lane_rdata;

    axi_write_ctrl #(.DEPTH_BITS(DEPTH_BITS)) axi_write_ctrl_inst (
        .ACLK, .ARESETn,
        .aw_id, .aw_addr, .aw_len, .aw_size, .aw_burst, .aw_valid, .aw_ready,
        .w_data, .w_strb, .w_last, .w_valid, .w_ready,
        .b_id, .b_resp, .b_valid, .b_ready,
        .wr_req, .wr_gnt, .wr_word_addr, .wr_data, .wr_strb
    );

    axi_read_ctrl #(.DEPTH_BITS(DEPTH_BITS)) axi_read_ctrl_inst (
        .ACLK, .ARESETn,
        .ar_id, .ar_addr, .ar_len, .ar_size, .ar_burst, .ar_valid, .ar_ready,
        .r_id, .r_data, .r_resp, .r_last, .r_valid, .r_ready,
        .rd_req, .rd_gnt, .rd_word_addr, .lane_rdata
    );

    sram_port_arb #(.DEPTH_BITS(DEPTH_BITS)) sram_port_arb_inst (
        .ACLK, .ARESETn,
        .wr_req, .wr_word_addr, .wr_data, .wr_strb,
        .rd_req, .rd_word_addr,
        .wr_gnt, .rd_gnt,
        .lane_en, .lane_we, .lane_addr, .lane_wdata
    );

    // byte lane i holds bits 8*i+7 to 8*i of each word
    for (genvar i = 0; i < SRAM_LANES; i++) begin : g_lane
        sram_byte_lane #(.DEPTH_BITS(DEPTH_BITS)) sram_byte_lane_inst (
            .ACLK  (ACLK),
            .en    (lane_en),
            .we    (lane_we[i]),
            .addr  (lane_addr),
            .wdata (lane_wdata[i]),
            .rdata (lane_rdata[i])
        );
    end

endmodule

// File: hw/axi_read_ctrl.sv
`timescale 1ns/1ps

module axi_read_ctrl import axi_pkg::*, sram_pkg::*; #(
    parameter int DEPTH_BITS = 14
) (
    input  logic                   ACLK,
    input  logic                   ARESETn,
    input  axi_id_t                ar_id,
    input  axi_addr_t              ar_addr,
    input  axi_len_t               ar_len,
    input  axi_size_t              ar_size,
    input  axi_burst_t             ar_burst,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    output axi_id_t                r_id,
    output axi_data_t              r_data,
    output axi_resp_t              r_resp,
    output logic                   r_last,
    output logic                   r_valid,
    input  logic                   r_ready,
    output logic                   rd_req,
    input  logic                   rd_gnt,
    output logic [DEPTH_BITS-1:0]  rd_word_addr,
    input  byte_t [SRAM_LANES-1:0] lane_rdata
);

    // ISSUE asks for the port, FILL takes lane data, HOLD waits for r_ready
    typedef enum logic [1:0] {IDLE, ISSUE, FILL, HOLD} state_t;

    state_t     state;
    axi_id_t    id_q;
    axi_addr_t  addr_q;
    axi_len_t   len_q;
    axi_len_t   cnt_q;  // current beat number
    axi_size_t  size_q;
    axi_burst_t burst_q;
    axi_resp_t  err_q;
    axi_resp_t  ar_err;
    logic       good;

    always_comb begin
        if (ar_size > 3'd2 || (ar_burst != BURST_FIXED && ar_burst != BURST_INCR)) begin
            ar_err = RESP_SLVERR;
        end else if (!addr_in_window(ar_addr)) begin
            ar_err = RESP_DECERR;
        end else begin
            ar_err = RESP_OKAY;
        end
    end

    assign good         = (err_q == RESP_OKAY);
    assign ar_ready     = (state == IDLE);
    assign rd_req       = (state == ISSUE) && good;  // never while holding a beat
    assign rd_word_addr = addr_q[DEPTH_BITS+1:2];
    assign r_id         = id_q;
    assign r_resp       = err_q;  // constant for the burst

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state   <= IDLE;
            cnt_q   <= '0;
            r_valid <= 1'b0;
            r_last  <= 1'b0;
        end else begin
            case (state)
                IDLE: if (ar_valid) begin
                    cnt_q <= '0;
                    state <= ISSUE;
                end
                ISSUE: if (!good) begin
                    r_valid <= 1'b1;  // error beat skips the sram
                    r_last  <= (cnt_q == len_q);
                    state   <= HOLD;
                end else if (rd_gnt) begin
                    state <= FILL;
                end
                FILL: begin
                    r_valid <= 1'b1;
                    r_last  <= (cnt_q == len_q);
                    state   <= HOLD;
                end
                HOLD: if (r_ready) begin
                    r_valid <= 1'b0;
                    r_last  <= 1'b0;
                    if (r_last) begin
                        state <= IDLE;
                    end else begin
                        cnt_q <= cnt_q + 8'd1;
                        state <= ISSUE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (ar_valid && ar_ready) begin
            id_q    <= ar_id;
            addr_q  <= ar_addr;
            len_q   <= ar_len;
            size_q  <= ar_size;
            burst_q <= ar_burst;
            err_q   <= ar_err;
        end else if (state == HOLD && r_ready && burst_q == BURST_INCR) begin
            addr_q <= addr_q + (axi_addr_t'(1) << size_q);
        end
        if (state == ISSUE && !good) r_data <= '0;
        if (state == FILL) r_data <= lane_rdata;  // lanes registered at the grant edge
    end

endmodule

// File: hw/axi_write_ctrl.sv
`timescale 1ns/1ps

module axi_write_ctrl import axi_pkg::*, sram_pkg::*; #(
    parameter int DEPTH_BITS = 14
) (
    input  logic                  ACLK,
    input  logic                  ARESETn,
    input  axi_id_t               aw_id,
    input  axi_addr_t             aw_addr,
    input  axi_len_t              aw_len,
    input  axi_size_t             aw_size,
    input  axi_burst_t            aw_burst,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  axi_data_t             w_data,
    input  axi_strb_t             w_strb,
    input  logic                  w_last,
    input  logic                  w_valid,
    output logic                  w_ready,
    output axi_id_t               b_id,
    output axi_resp_t             b_resp,
    output logic                  b_valid,
    input  logic                  b_ready,
    output logic                  wr_req,
    input  logic                  wr_gnt,
    output logic [DEPTH_BITS-1:0] wr_word_addr,
    output axi_data_t             wr_data,
    output axi_strb_t             wr_strb
);

    typedef enum logic [1:0] {IDLE, DATA, RESP} state_t;

    state_t     state;
    axi_id_t    id_q;
    axi_addr_t  addr_q;   // current beat address
    axi_len_t   len_q;
    axi_len_t   cnt_q;    // beats accepted so far
    axi_size_t  size_q;
    axi_burst_t burst_q;
    axi_resp_t  err_q;    // response for the whole burst
    axi_resp_t  aw_err;
    logic       good;
    logic       beat;
    logic       last_beat;

    // size and burst type first, then the decode window
    always_comb begin
        if (aw_size > 3'd2 || (aw_burst != BURST_FIXED && aw_burst != BURST_INCR)) begin
            aw_err = RESP_SLVERR;
        end else if (!addr_in_window(aw_addr)) begin
            aw_err = RESP_DECERR;
        end else begin
            aw_err = RESP_OKAY;
        end
    end

    assign good     = (err_q == RESP_OKAY);
    assign aw_ready = (state == IDLE);
    assign wr_req   = (state == DATA) && good && w_valid;  // only with real data
    assign w_ready  = (state == DATA) && (good ? wr_gnt : 1'b1);  // error beats just drain
    assign beat     = w_valid && w_ready;
    // burst ends on w_last or on the length count
    assign last_beat = w_last || (cnt_q == len_q);

    assign b_valid = (state == RESP);
    assign b_id    = id_q;
    assign b_resp  = err_q;

    assign wr_word_addr = addr_q[DEPTH_BITS+1:2];
    assign wr_data      = w_data;
    assign wr_strb      = w_strb;  // lanes follow the strobes directly

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state <= IDLE;
            cnt_q <= '0;
        end else begin
            case (state)
                IDLE: if (aw_valid) begin
                    cnt_q <= '0;
                    state <= DATA;
                end
                DATA: if (beat) begin
                    cnt_q <= cnt_q + 8'd1;
                    if (last_beat) state <= RESP;  // b_valid next cycle
                end
                RESP: if (b_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // burst payload
    always_ff @(posedge ACLK) begin
        if (aw_valid && aw_ready) begin
            id_q    <= aw_id;
            addr_q  <= aw_addr;
            len_q   <= aw_len;
            size_q  <= aw_size;
            burst_q <= aw_burst;
            err_q   <= aw_err;
        end else if (beat && burst_q == BURST_INCR) begin
            addr_q <= addr_q + (axi_addr_t'(1) << size_q);  // fixed keeps it
        end
    end

endmodule

// File: hw/sram_byte_lane.sv
`timescale 1ns/1ps

module sram_byte_lane import sram_pkg::*; #(
    parameter int DEPTH_BITS = 14
) (
    input  logic                  ACLK,
    input  logic                  en,
    input  logic                  we,
    input  logic [DEPTH_BITS-1:0] addr,
    input  byte_t                 wdata,
    output byte_t                 rdata
);

    byte_t mem [2**DEPTH_BITS];  // one byte per word address

    // single port, write or read per enabled cycle
    always_ff @(posedge ACLK) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];  // valid the cycle after the access
            end
        end
    end

endmodule

// File: hw/sram_port_arb.sv
`timescale 1ns/1ps

module sram_port_arb import sram_pkg::*; #(
    parameter int DEPTH_BITS = 14
) (
    input  logic                         ACLK,
    input  logic                         ARESETn,
    input  logic                         wr_req,
    input  logic [DEPTH_BITS-1:0]        wr_word_addr,
    input  byte_t [SRAM_LANES-1:0]       wr_data,
    input  logic [SRAM_LANES-1:0]        wr_strb,
    input  logic                         rd_req,
    input  logic [DEPTH_BITS-1:0]        rd_word_addr,
    output logic                         wr_gnt,
    output logic                         rd_gnt,
    output logic                         lane_en,
    output logic [SRAM_LANES-1:0]        lane_we,
    output logic [DEPTH_BITS-1:0]        lane_addr,
    output byte_t [SRAM_LANES-1:0]       lane_wdata
);

    logic last_wr;  // last grant went to the write side

    // lone requester wins at once, on a tie the side not served last time wins
    assign wr_gnt = wr_req && (!rd_req || !last_wr);
    assign rd_gnt = rd_req && !wr_gnt;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            last_wr <= 1'b0;  // write side first after reset
        end else if (wr_gnt) begin
            last_wr <= 1'b1;
        end else if (rd_gnt) begin
            last_wr <= 1'b0;
        end
    end

    // single port shared by all lanes
    assign lane_en    = wr_gnt || rd_gnt;
    assign lane_addr  = wr_gnt ? wr_word_addr : rd_word_addr;
    assign lane_we    = wr_strb & {SRAM_LANES{wr_gnt}};  // strobe bit per lane
    assign lane_wdata = wr_data;  // each lane picks its own byte

endmodule

// File: hw/sram_pkg.sv
package sram_pkg;

    // 32-bit word split into four independent byte memories
    localparam int SRAM_LANES = 4;

    typedef logic [7:0] byte_t;  // one lane's data

    // 64 KB decode window, starts at byte 0
    localparam int unsigned SRAM_BYTES = 65536;

    // true when the byte address falls inside the window
    function automatic logic addr_in_window(input logic [31:0] addr);
        return addr < SRAM_BYTES;
    endfunction

endpackage

// File: hw/axi_pkg.sv
package axi_pkg;

    // AXI4 field widths used on the slave ports
    typedef logic [3:0]  axi_id_t;    // transaction id
    typedef logic [31:0] axi_addr_t;  // byte address
    typedef logic [7:0]  axi_len_t;   // beats minus one
    typedef logic [2:0]  axi_size_t;  // log2 bytes per beat
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_resp_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;  // one bit per byte lane

    // burst encodings, WRAP (2'b10) is not supported here
    localparam axi_burst_t BURST_FIXED = 2'b00;
    localparam axi_burst_t BURST_INCR  = 2'b01;

    // response codes
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;  // bad size or burst type
    localparam axi_resp_t RESP_DECERR = 2'b11;  // outside the sram window

endpackage
